//--- project.f
common/rv_pkg.sv
hw/fetch_unit.sv
hw/ins_queue.sv
exec/reg_file.sv
exec/data_mem.sv
exec/exec_unit.sv
hw/rv_core_top.sv
bench/fetch_props.sv
bench/tb_rv_core.sv

//--- bench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

    localparam int    QUEUE_DEPTH    = 4;
    localparam int    DMEM_WORDS     = 256;
    localparam word_t RESET_PC       = '0;
    localparam int    PROG_LEN       = 200;
    localparam int    RAM_SLOTS      = 16;
    localparam word_t RAM_BASE       = 32'h0000_0100;
    localparam word_t NOP_WORD       = 32'h0000_0013;
    localparam word_t SEED           = 32'd37933;
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 3 * 2 + 100;
    localparam logic [2:0] ALU_F3 [4] = '{F3_ADD_SUB, F3_XOR, F3_OR, F3_AND};

    logic      sys_clk = 1'b0;
    logic      sys_rst;
    imem_req_t imem_req;
    imem_rsp_t imem_rsp;
    word_t     gpio_in;
    word_t     gpio_out;
    retire_t   retire;

    word_t     prog [PROG_LEN];
    word_t     model_regs [32];
    word_t     model_ram [DMEM_WORDS];
    word_t     model_gpio_out;
    word_t     lcg_state;
    imem_req_t req_seen = '0;
    word_t     gpio_seen;
    retire_t   exp_ret;
    int        cycles;
    int        req_count;
    int        rsp_count;
    int        ret_count;
    int        neg_count;

    rv_core_top dut (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .retire   (retire)
    );

    always #10 sys_clk = ~sys_clk;

    // ================================================
    // random numbers and encoders
    // ================================================
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % n);
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
            input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
            input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
            input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < PROG_LEN) ? prog[idx] : NOP_WORD;
    endfunction

    // x30 points at RAM and x31 at GPIO
    // random code only writes x0..x29
    task automatic build_program();
        int         n;
        int         k;
        logic [2:0] f3;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        n = 0;
        for (k = 1; k < 30; k++) begin
            prog[n]     = enc_u(20'(lcg_next()), reg_idx_t'(k));
            prog[n + 1] = enc_i(12'(lcg_next()), reg_idx_t'(k), F3_ADD_SUB,
                                reg_idx_t'(k), OPC_OP_IMM);
            n += 2;
        end
        prog[n]     = enc_u(20'(RAM_BASE >> 12), 5'd30);
        prog[n + 1] = enc_i(12'(RAM_BASE), 5'd30, F3_ADD_SUB, 5'd30, OPC_OP_IMM);
        prog[n + 2] = enc_u(20'(IO_BASE >> 12), 5'd31);
        prog[n + 3] = enc_i(12'h000, 5'd31, F3_ADD_SUB, 5'd31, OPC_OP_IMM);
        n += 4;
        // fill every RAM slot before any load
        for (k = 0; k < RAM_SLOTS; k++) begin
            prog[n] = enc_s(12'(4 * k), reg_idx_t'(k + 1), 5'd30);
            n++;
        end
        while (n < PROG_LEN) begin
            f3  = ALU_F3[rand_below(4)];
            rd  = reg_idx_t'(rand_below(30));
            rs1 = reg_idx_t'(rand_below(32));
            rs2 = reg_idx_t'(rand_below(32));
            case (rand_below(10))
                0, 1, 2: prog[n] = enc_i(12'(lcg_next()), rs1, f3, rd, OPC_OP_IMM);
                3, 4, 5: begin
                    prog[n] = enc_r((f3 == F3_ADD_SUB && rand_below(2) == 1) ? F7_SUB : 7'd0,
                                    rs2, rs1, f3, rd);
                end
                6: prog[n] = enc_u(20'(lcg_next()), rd);
                7: begin
                    if (rand_below(4) == 0) prog[n] = enc_s(12'(GPIO_OUT_OFS), rs2, 5'd31);
                    else prog[n] = enc_s(12'(4 * rand_below(RAM_SLOTS)), rs2, 5'd30);
                end
                8: begin
                    if (rand_below(4) == 0) begin
                        prog[n] = enc_i(12'(GPIO_IN_OFS), 5'd31, F3_WORD, rd, OPC_LOAD);
                    end else begin
                        prog[n] = enc_i(12'(4 * rand_below(RAM_SLOTS)), 5'd30, F3_WORD, rd,
                                        OPC_LOAD);
                    end
                end
                default: prog[n] = enc_i(12'(lcg_next()), rs1, f3, 5'd0, OPC_OP_IMM);
            endcase
            n++;
        end
    endtask

    // ================================================
    // reference model stepped once per instruction
    // ================================================
    task automatic model_step(input word_t w, input word_t pc, output retire_t exp);
        word_t a;
        word_t b;
        word_t val;
        word_t addr;
        logic  writes;
        a      = model_regs[w[19:15]];
        b      = model_regs[w[24:20]];
        val    = '0;
        writes = 1'b0;
        if (w[6:0] == OPC_OP_IMM || w[6:0] == OPC_OP) begin
            if (w[6:0] == OPC_OP_IMM) b = {{20{w[31]}}, w[31:20]};
            writes = 1'b1;
            case (w[14:12])
                F3_ADD_SUB: val = (w[6:0] == OPC_OP && w[31:25] == F7_SUB) ? a - b : a + b;
                F3_XOR:     val = a ^ b;
                F3_OR:      val = a | b;
                F3_AND:     val = a & b;
                default:    writes = 1'b0;
            endcase
        end else if (w[6:0] == OPC_LUI) begin
            writes = 1'b1;
            val    = {w[31:12], 12'h000};
        end else if (w[6:0] == OPC_LOAD && w[14:12] == F3_WORD) begin
            writes = 1'b1;
            addr   = a + {{20{w[31]}}, w[31:20]};
            if (!addr[28]) val = model_ram[(addr >> 2) % DMEM_WORDS];
            else if ((addr & ~IO_BASE) == GPIO_IN_OFS) val = gpio_seen;
            else if ((addr & ~IO_BASE) == GPIO_OUT_OFS) val = model_gpio_out;
        end else if (w[6:0] == OPC_STORE && w[14:12] == F3_WORD) begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            if (!addr[28]) model_ram[(addr >> 2) % DMEM_WORDS] = b;
            else if ((addr & ~IO_BASE) == GPIO_OUT_OFS) model_gpio_out = b;
        end
        exp.valid  = 1'b1;
        exp.pc     = pc;
        exp.rd     = w[11:7];
        exp.rd_we  = writes && (w[11:7] != 5'd0);
        exp.rd_val = val;
        if (exp.rd_we) model_regs[w[11:7]] = val;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.valid !== exp.valid || got.pc !== exp.pc || got.rd !== exp.rd ||
                got.rd_we !== exp.rd_we || (exp.rd_we && got.rd_val !== exp.rd_val)) begin
            abort_run($sformatf({"FAIL t=%0t retire got pc=%h rd=%0d we=%b val=%h,",
                                 " expected pc=%h rd=%0d we=%b val=%h"}, $time,
                                got.pc, got.rd, got.rd_we, got.rd_val,
                                exp.pc, exp.rd, exp.rd_we, exp.rd_val));
        end
    endtask

    task automatic check_gpio(input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t gpio_out got %h, expected %h", $time, got, exp));
        end
    endtask

    // ================================================
    // instruction memory and gpio input
    // ================================================
    always @(negedge sys_clk) begin
        imem_rsp.valid = req_seen.valid;
        imem_rsp.data  = req_seen.valid ? fetch_word(req_seen.addr) : '0;
        if (neg_count % 16 == 0) gpio_in = lcg_next();
        neg_count++;
    end

    // sampling and checks on the rising edge
    always @(posedge sys_clk) begin
        cycles    <= cycles + 1;
        req_seen  <= sys_rst ? '0 : imem_req;
        gpio_seen <= gpio_in;
        if (sys_rst) begin
            if (cycles >= 1 && imem_req.valid !== 1'b0) begin
                abort_run("instruction request raised while reset was held");
            end
        end else begin
            req_count = req_count + int'(imem_req.valid);
            rsp_count = rsp_count + int'(imem_rsp.valid);
            if (rsp_count == 0 && req_count > QUEUE_DEPTH) begin
                abort_run("more requests than queue slots before the first response");
            end
            if (req_count > ret_count + QUEUE_DEPTH + 1) begin
                abort_run("fetch ran ahead of the credit limit");
            end
            if (retire.valid === 1'b1 && ret_count < PROG_LEN) begin
                model_step(prog[ret_count], RESET_PC + 32'(4 * ret_count), exp_ret);
                check_retire(retire, exp_ret);
                check_gpio(gpio_out, model_gpio_out);
                ret_count = ret_count + 1;
            end
        end
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        abort_run($sformatf("timeout after %0d cycles with %0d of %0d instructions retired",
                            cycles, ret_count, PROG_LEN));
    end

    initial begin
        sys_rst        = 1'b1;
        imem_rsp       = '0;
        gpio_in        = '0;
        model_gpio_out = '0;
        lcg_state      = SEED;
        foreach (model_regs[k]) model_regs[k] = '0;
        build_program();
        repeat (5) @(negedge sys_clk);
        sys_rst = 1'b0;
        wait (ret_count == PROG_LEN);
        @(negedge sys_clk);
        check_gpio(gpio_out, model_gpio_out);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/fetch_props.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_props import rv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input wire                               sys_clk,
    input wire                               sys_rst,
    input wire                               credit,
    input wire [$clog2(QUEUE_DEPTH + 1)-1:0] credits,
    input wire imem_req_t                    imem_req
);

    // requests seen on the port whose credit has not come back yet
    int in_use;

    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            in_use <= 0;
        end else begin
            in_use <= in_use + int'(imem_req.valid) - int'(credit);
        end
    end

    // counter never above the number of queue slots
    credits_bounded: assert property (@(posedge sys_clk) disable iff (sys_rst)
        credits <= QUEUE_DEPTH)
        else $error("credit count above queue depth");

    // a request always finds a free queue slot
    no_req_without_credit: assert property (@(posedge sys_clk) disable iff (sys_rst)
        imem_req.valid |-> (in_use < QUEUE_DEPTH))
        else $error("request issued with no credit left");

    // a returned credit always has room
    refund_has_room: assert property (@(posedge sys_clk) disable iff (sys_rst)
        credit |-> (credits < QUEUE_DEPTH))
        else $error("credit returned while counter was full");

    quiet_in_reset: assert property (@(posedge sys_clk)
        sys_rst |=> !imem_req.valid)
        else $error("request valid while reset held");

endmodule

bind fetch_unit fetch_props #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_fetch_props (
    .sys_clk  (sys_clk),
    .sys_rst  (sys_rst),
    .credit   (credit),
    .credits  (credits),
    .imem_req (imem_req)
);

`default_nettype wire

//--- hw/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_top import rv_pkg::*; #(
    parameter int    QUEUE_DEPTH = 4,
    parameter int    DMEM_WORDS  = 256,
    parameter word_t RESET_PC    = '0
) (
    input  wire            sys_clk,
    input  wire            sys_rst,
    output imem_req_t      imem_req,
    input  wire imem_rsp_t imem_rsp,
    input  wire word_t     gpio_in,
    output word_t          gpio_out,
    output retire_t        retire
);

    logic  credit;
    logic  head_valid;
    logic  pop;
    word_t head_word;

    // ================================================
    // fetch -> queue -> execute
    // ================================================
    fetch_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_fetch_unit (
        .sys_clk  (sys_clk),
        .sys_rst  (sys_rst),
        .credit   (credit),
        .imem_req (imem_req)
    );

    // responses land straight in the queue
    ins_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_ins_queue (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .push       (imem_rsp),
        .pop        (pop),
        .head_valid (head_valid),
        .head_word  (head_word),
        .credit     (credit)
    );

    exec_unit #(
        .DMEM_WORDS (DMEM_WORDS),
        .RESET_PC   (RESET_PC)
    ) u_exec_unit (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .head_valid (head_valid),
        .head_word  (head_word),
        .pop        (pop),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out),
        .retire     (retire)
    );

endmodule

`default_nettype wire

//--- exec/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_pkg::*; #(
    parameter int    DMEM_WORDS = 256,
    parameter word_t RESET_PC   = '0
) (
    input  wire        sys_clk,
    input  wire        sys_rst,
    input  wire        head_valid,
    input  wire word_t head_word,
    output logic       pop,
    input  wire word_t gpio_in,
    output word_t      gpio_out,
    output retire_t    retire
);

    typedef enum logic [1:0] {IDLE, READ, EXEC, WRITE} state_t;

    state_t state;
    insn_u  insn;
    word_t  pc;
    word_t  op_a, op_b, res;
    word_t  rs1_val, rs2_val, dmem_rdata;
    word_t  imm_i, imm_s, imm_u;
    word_t  alu_b, alu_out, mem_addr, wb_val;
    logic   is_op_imm, is_op, is_load, is_store, is_lui;
    logic   f3_ok, writes_rd, rd_we;

    assign pop = (state == IDLE) && head_valid;

    // ================================================
    // sequencer
    // ================================================
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            state <= IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                IDLE:  if (head_valid) state <= READ;
                READ:  state <= EXEC;
                EXEC:  state <= WRITE;
                WRITE: begin
                    state <= IDLE;
                    pc    <= pc + 32'd4;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pop) insn <= head_word;
        if (state == READ) begin
            op_a <= rs1_val;
            op_b <= rs2_val;
        end
        if (state == EXEC) res <= alu_out;
    end

    // ================================================
    // decode and ALU
    // ================================================
    assign is_op_imm = (insn.r.opcode == OPC_OP_IMM);
    assign is_op     = (insn.r.opcode == OPC_OP);
    assign is_lui    = (insn.r.opcode == OPC_LUI);
    assign is_load   = (insn.r.opcode == OPC_LOAD) && (insn.i.funct3 == F3_WORD);
    assign is_store  = (insn.r.opcode == OPC_STORE) && (insn.s.funct3 == F3_WORD);

    assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
    assign imm_s = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
    assign imm_u = {insn.u.imm, 12'h000};

    always_comb begin
        alu_b = is_op ? op_b : imm_i;
        f3_ok = 1'b1;
        case (insn.r.funct3)
            F3_ADD_SUB: begin
                if (is_op && insn.r.funct7 == F7_SUB) alu_out = op_a - alu_b;
                else alu_out = op_a + alu_b;
            end
            F3_XOR: alu_out = op_a ^ alu_b;
            F3_OR:  alu_out = op_a | alu_b;
            F3_AND: alu_out = op_a & alu_b;
            default: begin
                alu_out = '0;
                f3_ok   = 1'b0;
            end
        endcase
        if (is_lui) alu_out = imm_u;
    end

    assign mem_addr  = op_a + (is_store ? imm_s : imm_i);
    assign writes_rd = ((is_op_imm || is_op) && f3_ok) || is_lui || is_load;
    assign rd_we     = writes_rd && (insn.r.rd != '0);
    assign wb_val    = is_load ? dmem_rdata : res;

    // retire report, WRITE lasts exactly one cycle
    always_comb begin
        retire.valid  = (state == WRITE);
        retire.pc     = pc;
        retire.rd     = insn.r.rd;
        retire.rd_we  = rd_we;
        retire.rd_val = wb_val;
    end

    reg_file u_reg_file (
        .sys_clk (sys_clk),
        .rs1     (insn.r.rs1),
        .rs2     (insn.r.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      ((state == WRITE) && rd_we),
        .rd      (insn.r.rd),
        .rd_val  (wb_val)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .sys_clk   (sys_clk),
        .sys_rst   (sys_rst),
        .req_valid ((state == EXEC) && (is_load || is_store)),
        .req_write (is_store),
        .addr      (mem_addr),
        .wdata     (op_b),
        .rdata     (dmem_rdata),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out)
    );

endmodule

`default_nettype wire

//--- exec/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  wire        sys_clk,
    input  wire        sys_rst,
    input  wire        req_valid,
    input  wire        req_write,
    input  wire word_t addr,
    input  wire word_t wdata,
    output word_t      rdata,
    input  wire word_t gpio_in,
    output word_t      gpio_out
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t            ram [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    word_t            io_ofs;
    logic             is_io;

    // ================================================
    // address decode
    // ================================================
    assign is_io    = |(addr & IO_BASE);
    assign io_ofs   = addr & ~IO_BASE;
    assign word_idx = IDX_W'((addr >> 2) % DMEM_WORDS);

    always_ff @(posedge sys_clk) begin
        if (req_valid && req_write && !is_io) begin
            ram[word_idx] <= wdata;
        end
        // one cycle read latency
        if (req_valid && !req_write) begin
            if (!is_io) rdata <= ram[word_idx];
            else if (io_ofs == GPIO_IN_OFS) rdata <= gpio_in;
            else if (io_ofs == GPIO_OUT_OFS) rdata <= gpio_out;
            else rdata <= '0;
        end
    end

    // gpio output register
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            gpio_out <= '0;
        end else if (req_valid && req_write && is_io && io_ofs == GPIO_OUT_OFS) begin
            gpio_out <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- exec/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire           sys_clk,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output word_t         rs1_val,
    output word_t         rs2_val,
    input  wire           we,
    input  wire reg_idx_t rd,
    input  wire word_t    rd_val
);

    word_t regs [32];

    // x0 is never stored, reads force zero
    always_ff @(posedge sys_clk) begin
        if (we && rd != '0) begin
            regs[rd] <= rd_val;
        end
    end

    // asynchronous read ports
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hw/ins_queue.sv
`timescale 1ns/1ps
`default_nettype none

module ins_queue import rv_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire            sys_clk,
    input  wire            sys_rst,
    input  wire imem_rsp_t push,
    input  wire            pop,
    output logic           head_valid,
    output word_t          head_word,
    output logic           credit
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // credits bound occupancy, so push needs no check
    assign do_pop     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head_word  = mem[rd_ptr];

    always_ff @(posedge sys_clk) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.data;
        end
    end

    // ================================================
    // pointers, occupancy, credit return
    // ================================================
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push.valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + CNT_W'(push.valid) - CNT_W'(do_pop);
            // one credit per freed slot
            credit <= do_pop;
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rv_pkg::*; #(
    parameter int    QUEUE_DEPTH = 4,
    parameter word_t RESET_PC    = '0
) (
    input  wire       sys_clk,
    input  wire       sys_rst,
    input  wire       credit,
    output imem_req_t imem_req
);

    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    logic [CNT_W-1:0] credits;
    word_t            pc;
    imem_req_t        req_q;
    logic             issue;

    // one request per cycle while any slot is free
    assign issue = (credits != '0);

    // ================================================
    // PC and credit counter
    // ================================================
    always_ff @(posedge sys_clk) begin
        if (sys_rst) begin
            pc      <= RESET_PC;
            credits <= CNT_W'(QUEUE_DEPTH);
        end else begin
            if (issue) begin
                pc <= pc + 32'd4;
            end
            // spend on issue, refund on each pop
            credits <= credits - CNT_W'(issue) + CNT_W'(credit);
        end
    end

    // registered request towards instruction memory
    always_ff @(posedge sys_clk) begin
        req_q.addr <= pc;
        if (sys_rst) begin
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= issue;
        end
    end

    assign imem_req = req_q;

endmodule

`default_nettype wire

//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ================================================
    // widths and base types
    // ================================================
    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ================================================
    // RV32I encodings, kept subset
    // ================================================
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // data space map, bit 28 selects GPIO
    localparam word_t IO_BASE      = 32'h1000_0000;
    localparam word_t GPIO_OUT_OFS = 32'h0000_0000;
    localparam word_t GPIO_IN_OFS  = 32'h0000_0004;

    // ================================================
    // instruction formats
    // ================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one word, four views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } insn_u;

    // ================================================
    // port bundles
    // ================================================
    typedef struct packed {
        logic  valid;
        word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } imem_rsp_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_we;
        word_t    rd_val;
    } retire_t;

endpackage

`default_nettype wire
